/* all.f */
source/mem_pkg.sv
source/mem_req_if.sv
source/mem_op_decode.sv
source/data_bus_master.sv
source/load_extend.sv
source/mem_stage.sv
test/clock_gen.sv
test/bus_memory_model.sv
test/mem_stage_tb.sv

/* run.sh */
#!/bin/sh
# builds the memory stage testbench with Verilator and runs it;
# exits non-zero on a build error, a crash or a missing pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_stage_tb -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vmem_stage_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* source/data_bus_master.sv */
/* read and write bus masters: latch one pending request each and run the
   address, data and response handshakes; reports done levels and bus errors */
`default_nettype none

module data_bus_master (
    input  logic            clk,
    input  logic            rst,
    mem_req_if.master       req,
    // read address / read data
    output logic            ar_valid,
    input  logic            ar_ready,
    output mem_pkg::addr_t  ar_addr,
    output mem_pkg::size_t  ar_size,
    input  logic            r_valid,
    output logic            r_ready,
    // write address / write data / write response
    output logic            aw_valid,
    input  logic            aw_ready,
    output mem_pkg::addr_t  aw_addr,
    output mem_pkg::size_t  aw_size,
    output logic            w_valid,
    input  logic            w_ready,
    output mem_pkg::word_t  w_data,
    output mem_pkg::strb_t  w_strb,
    input  logic            b_valid,
    output logic            b_ready,
    input  mem_pkg::resp_t  b_resp,
    // status
    output logic            rd_done_pulse,
    output logic            load_done,
    output logic            store_done,
    output logic            bus_error
);

    mem_pkg::bus_state_e rd_state;
    mem_pkg::bus_state_e wr_state;
    logic                rd_pending;
    logic                wr_pending;
    logic                aw_sent;
    logic                w_sent;
    logic                rd_accept;
    logic                wr_accept;
    logic                ar_fire;
    logic                b_fire;
    logic                wr_pair_done;

    // ========================================
    // read side
    assign rd_accept     = (rd_state == mem_pkg::IDLE) & ~rd_pending & req.rd_start;
    assign ar_valid      = (rd_state == mem_pkg::IDLE) & rd_pending;
    assign r_ready       = (rd_state == mem_pkg::BUSY);
    assign ar_fire       = ar_valid & ar_ready;
    assign rd_done_pulse = r_valid & r_ready;
    assign load_done     = (rd_state == mem_pkg::IDLE) & ~rd_pending & ~req.rd_start;

    // payload held for the whole handshake
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            ar_addr <= req.addr;
            ar_size <= req.size;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state   <= mem_pkg::IDLE;
            rd_pending <= 1'b0;
        end else begin
            if (rd_accept) begin
                rd_pending <= 1'b1;
            end else if (ar_fire) begin
                rd_pending <= 1'b0;
            end
            case (rd_state)
                mem_pkg::IDLE: if (ar_fire) rd_state <= mem_pkg::BUSY;
                default:       if (rd_done_pulse) rd_state <= mem_pkg::IDLE;
            endcase
        end
    end

    // ========================================
    // write side
    assign wr_accept    = (wr_state == mem_pkg::IDLE) & ~wr_pending & req.wr_start;
    assign aw_valid     = (wr_state == mem_pkg::IDLE) & wr_pending & ~aw_sent;
    assign w_valid      = (wr_state == mem_pkg::IDLE) & wr_pending & ~w_sent;
    assign b_ready      = (wr_state == mem_pkg::BUSY);
    assign b_fire       = b_valid & b_ready;
    assign store_done   = (wr_state == mem_pkg::IDLE) & ~wr_pending & ~req.wr_start;
    // both address and data accepted, now or in an earlier cycle
    assign wr_pair_done = wr_pending & ((aw_valid & aw_ready) | aw_sent)
                        & ((w_valid & w_ready) | w_sent);

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            aw_addr <= req.addr;
            aw_size <= req.size;
            w_data  <= req.wdata;
            w_strb  <= req.strb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state   <= mem_pkg::IDLE;
            wr_pending <= 1'b0;
            aw_sent    <= 1'b0;
            w_sent     <= 1'b0;
        end else if (wr_state == mem_pkg::IDLE) begin
            if (wr_pair_done) begin
                wr_state   <= mem_pkg::BUSY;
                wr_pending <= 1'b0;
                aw_sent    <= 1'b0;
                w_sent     <= 1'b0;
            end else begin
                wr_pending <= wr_pending | wr_accept;
                aw_sent    <= aw_sent | (aw_valid & aw_ready);
                w_sent     <= w_sent | (w_valid & w_ready);
            end
        end else if (b_fire) begin
            wr_state <= mem_pkg::IDLE;
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            bus_error <= 1'b0;
        end else if (b_fire && b_resp != mem_pkg::RESP_OKAY) begin
            bus_error <= 1'b1;
        end
    end

    ar_addr_stable: assert property (
        @(posedge clk) disable iff (rst) ar_valid && !ar_ready |=> $stable(ar_addr)
    );

    // read data only accepted once the address went out in the cycle before
    r_ready_after_ar: assert property (
        @(posedge clk) disable iff (rst) $rose(r_ready) |-> $past(ar_fire)
    );

endmodule

`default_nettype wire

/* source/load_extend.sv */
/* picks the addressed byte or half out of returned read data and sign- or
   zero-extends it; the result is held until the next load completes */
`default_nettype none

module load_extend (
    input  logic            clk,
    input  logic            rst,
    mem_req_if.result       req,
    input  logic            rd_done_pulse,
    input  mem_pkg::word_t  r_data,
    output mem_pkg::word_t  load_data
);

    mem_pkg::size_t size_q;
    logic           unsigned_q;
    logic [1:0]     lane_q;
    mem_pkg::word_t lane_data;
    mem_pkg::word_t extended;
    logic           fill;

    // request attributes, kept until the data comes back
    always_ff @(posedge clk) begin
        if (req.rd_start) begin
            size_q     <= req.size;
            unsigned_q <= req.is_unsigned;
            lane_q     <= req.addr[1:0];
        end
    end

    // addressed field moved down to bit 0
    assign lane_data = r_data >> {lane_q, 3'b000};

    always_comb begin
        case (size_q)
            mem_pkg::SIZE_BYTE: begin
                fill     = ~unsigned_q & lane_data[7];
                extended = {{24{fill}}, lane_data[7:0]};
            end
            mem_pkg::SIZE_HALF: begin
                fill     = ~unsigned_q & lane_data[15];
                extended = {{16{fill}}, lane_data[15:0]};
            end
            default: begin
                fill     = 1'b0;
                extended = r_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_data <= '0;
        end else if (rd_done_pulse) begin
            load_data <= extended;
        end
    end

endmodule

`default_nettype wire

/* source/mem_op_decode.sv */
/* decodes funct3 and the address of a load/store request into size, signedness,
   byte strobes and lane-aligned store data; misaligned requests are dropped */
`default_nettype none

module mem_op_decode (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_req,
    input  logic            store_req,
    input  mem_pkg::addr_t  addr,
    input  mem_pkg::word_t  store_data,
    input  mem_pkg::funct3_t funct3,
    output logic            misaligned,
    mem_req_if.decode       req
);

    mem_pkg::size_t size;
    logic           is_unsigned;
    logic           aligned;

    // ========================================
    // width and signedness
    always_comb begin
        case (funct3)
            mem_pkg::F3_B: begin
                size        = mem_pkg::SIZE_BYTE;
                is_unsigned = 1'b0;
            end
            mem_pkg::F3_H: begin
                size        = mem_pkg::SIZE_HALF;
                is_unsigned = 1'b0;
            end
            mem_pkg::F3_BU: begin
                size        = mem_pkg::SIZE_BYTE;
                is_unsigned = 1'b1;
            end
            mem_pkg::F3_HU: begin
                size        = mem_pkg::SIZE_HALF;
                is_unsigned = 1'b1;
            end
            // F3_W and unused codes fall back to a full word
            default: begin
                size        = mem_pkg::SIZE_WORD;
                is_unsigned = 1'b0;
            end
        endcase
    end

    // ========================================
    // lanes and alignment
    always_comb begin
        case (size)
            mem_pkg::SIZE_BYTE: begin
                req.strb = 4'b0001 << addr[1:0];
                aligned  = 1'b1;
            end
            mem_pkg::SIZE_HALF: begin
                req.strb = 4'b0011 << addr[1:0];
                aligned  = ~addr[0];
            end
            default: begin
                req.strb = 4'b1111;
                aligned  = (addr[1:0] == 2'b00);
            end
        endcase
    end

    assign req.wdata       = store_data << {addr[1:0], 3'b000};
    assign req.addr        = addr;
    assign req.size        = size;
    assign req.is_unsigned = is_unsigned;

    // bad accesses never reach the bus
    assign req.rd_start = load_req & aligned;
    assign req.wr_start = store_req & aligned;

    // set one cycle after the offending pulse, held until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            misaligned <= 1'b0;
        end else if ((load_req | store_req) & ~aligned) begin
            misaligned <= 1'b1;
        end
    end

    // the pipeline register issues one access kind per cycle
    one_op_per_cycle: assert property (
        @(posedge clk) disable iff (rst) !(load_req && store_req)
    );

endmodule

`default_nettype wire

/* source/mem_pkg.sv */
/* shared widths, bus size codes, RV32 load/store funct3 codes and write response codes,
   referenced by scoped name from every RTL file of the memory stage */
`default_nettype none

package mem_pkg;

    localparam int XLEN   = 32;
    localparam int STRB_W = XLEN / 8;

    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [XLEN-1:0]   word_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [2:0]        size_t;
    typedef logic [1:0]        resp_t;
    typedef logic [2:0]        funct3_t;

    // ========================================
    // bus transfer size, log2 of the byte count
    localparam size_t SIZE_BYTE = 3'd0;
    localparam size_t SIZE_HALF = 3'd1;
    localparam size_t SIZE_WORD = 3'd2;

    // ========================================
    // load/store funct3, bit 2 marks zero extension
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    // write response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // shared by the read and the write machine
    typedef enum logic [0:0] {
        IDLE,
        BUSY
    } bus_state_e;

endpackage

`default_nettype wire

/* source/mem_req_if.sv */
/* decoded load/store request, driven by the decoder and read by the bus master
   and by the load extension stage */
`default_nettype none

interface mem_req_if;

    // one-cycle start pulses, aligned accesses only
    logic            rd_start;
    logic            wr_start;

    mem_pkg::addr_t  addr;
    // store data already moved into its byte lanes
    mem_pkg::word_t  wdata;
    mem_pkg::size_t  size;
    mem_pkg::strb_t  strb;
    logic            is_unsigned;

    modport decode (
        output rd_start, wr_start, addr, wdata, size, strb, is_unsigned
    );

    modport master (
        input rd_start, wr_start, addr, wdata, size, strb
    );

    // load extension needs the width, signedness and byte offset
    modport result (
        input rd_start, addr, size, is_unsigned
    );

endinterface

`default_nettype wire

/* source/mem_stage.sv */
/* data memory access block of the memory stage: decode, bus master and load
   extension joined to the pipeline ports and to the read and write buses */
`default_nettype none

module mem_stage (
    input  logic             clk,
    input  logic             rst,
    // pipeline side
    input  logic             load_req,
    input  logic             store_req,
    input  mem_pkg::addr_t   addr,
    input  mem_pkg::word_t   store_data,
    input  mem_pkg::funct3_t funct3,
    output mem_pkg::word_t   load_data,
    output logic             load_done,
    output logic             store_done,
    output logic             error,
    // ========================================
    // read bus
    output logic             ar_valid,
    input  logic             ar_ready,
    output mem_pkg::addr_t   ar_addr,
    output mem_pkg::size_t   ar_size,
    input  logic             r_valid,
    output logic             r_ready,
    input  mem_pkg::word_t   r_data,
    // ========================================
    // write bus
    output logic             aw_valid,
    input  logic             aw_ready,
    output mem_pkg::addr_t   aw_addr,
    output mem_pkg::size_t   aw_size,
    output logic             w_valid,
    input  logic             w_ready,
    output mem_pkg::word_t   w_data,
    output mem_pkg::strb_t   w_strb,
    input  logic             b_valid,
    output logic             b_ready,
    input  mem_pkg::resp_t   b_resp
);

    logic misaligned;
    logic bus_error;
    logic rd_done_pulse;

    mem_req_if req_bus ();

    mem_op_decode decode_i (
        .clk        (clk),
        .rst        (rst),
        .load_req   (load_req),
        .store_req  (store_req),
        .addr       (addr),
        .store_data (store_data),
        .funct3     (funct3),
        .misaligned (misaligned),
        .req        (req_bus.decode)
    );

    data_bus_master master_i (
        .clk (clk), .rst (rst), .req (req_bus.master),
        .ar_valid (ar_valid), .ar_ready (ar_ready), .ar_addr (ar_addr), .ar_size (ar_size),
        .r_valid (r_valid), .r_ready (r_ready),
        .aw_valid (aw_valid), .aw_ready (aw_ready), .aw_addr (aw_addr), .aw_size (aw_size),
        .w_valid (w_valid), .w_ready (w_ready), .w_data (w_data), .w_strb (w_strb),
        .b_valid (b_valid), .b_ready (b_ready), .b_resp (b_resp),
        .rd_done_pulse (rd_done_pulse),
        .load_done (load_done), .store_done (store_done), .bus_error (bus_error)
    );

    load_extend extend_i (
        .clk           (clk),
        .rst           (rst),
        .req           (req_bus.result),
        .rd_done_pulse (rd_done_pulse),
        .r_data        (r_data),
        .load_data     (load_data)
    );

    // both sources are sticky
    assign error = misaligned | bus_error;

endmodule

`default_nettype wire

/* test/bus_memory_model.sv */
/* bus memory for the testbench: 16 words behind the read and write channels,
   programmable ready/valid delays, one error address and transfer counters */
`default_nettype none

module bus_memory_model (
    input  logic            clk,
    input  logic            rst,
    // delays in cycles before each ready or response valid
    input  int              ar_delay,
    input  int              r_delay,
    input  int              aw_delay,
    input  int              w_delay,
    input  int              b_delay,
    input  mem_pkg::addr_t  err_addr,
    input  logic            ar_valid,
    output logic            ar_ready,
    input  mem_pkg::addr_t  ar_addr,
    output logic            r_valid,
    input  logic            r_ready,
    output mem_pkg::word_t  r_data,
    input  logic            aw_valid,
    output logic            aw_ready,
    input  mem_pkg::addr_t  aw_addr,
    input  logic            w_valid,
    output logic            w_ready,
    input  mem_pkg::word_t  w_data,
    input  mem_pkg::strb_t  w_strb,
    output logic            b_valid,
    input  logic            b_ready,
    output mem_pkg::resp_t  b_resp,
    output int              ar_count,
    output int              aw_count,
    output mem_pkg::strb_t  last_strb,
    output int              hold_errors
);

    mem_pkg::word_t mem [0:15];
    mem_pkg::addr_t rd_addr;
    mem_pkg::addr_t wr_addr;
    mem_pkg::word_t wr_data;
    mem_pkg::strb_t wr_strb;
    int             rd_hold_errs;
    int             wr_hold_errs;

    // payload changes or dropped valids while a ready is held back
    assign hold_errors = rd_hold_errs + wr_hold_errs;

    // ========================================
    // read address and read data
    initial begin
        ar_ready     = 1'b0;
        r_valid      = 1'b0;
        r_data       = '0;
        ar_count     = 0;
        rd_hold_errs = 0;
        forever begin
            @(negedge clk);
            if (!rst && ar_valid) begin
                rd_addr = ar_addr;
                repeat (ar_delay) begin
                    @(negedge clk);
                    if (!ar_valid || ar_addr !== rd_addr) rd_hold_errs++;
                end
                ar_ready = 1'b1;
                ar_count++;
                @(negedge clk);
                ar_ready = 1'b0;
                repeat (r_delay) @(negedge clk);
                r_valid = 1'b1;
                r_data  = mem[rd_addr[5:2]];
                while (!r_ready) @(negedge clk);
                @(negedge clk);
                r_valid = 1'b0;
            end
        end
    end

    // ========================================
    // write address, write data, write response
    initial begin
        aw_ready     = 1'b0;
        w_ready      = 1'b0;
        b_valid      = 1'b0;
        b_resp       = mem_pkg::RESP_OKAY;
        aw_count     = 0;
        last_strb    = '0;
        wr_hold_errs = 0;
        // fill pattern built from the word index
        for (int i = 0; i < 16; i++) mem[i] = {16'hc0de, 8'(i), 8'(~i)};
        forever begin
            @(negedge clk);
            if (!rst && aw_valid && w_valid) begin
                wr_addr = aw_addr;
                wr_data = w_data;
                wr_strb = w_strb;
                fork
                    begin
                        repeat (aw_delay) begin
                            @(negedge clk);
                            if (!aw_valid || aw_addr !== wr_addr) wr_hold_errs++;
                        end
                        aw_ready = 1'b1;
                        @(negedge clk);
                        aw_ready = 1'b0;
                    end
                    begin
                        repeat (w_delay) begin
                            @(negedge clk);
                            if (!w_valid || w_data !== wr_data || w_strb !== wr_strb) begin
                                wr_hold_errs++;
                            end
                        end
                        w_ready = 1'b1;
                        @(negedge clk);
                        w_ready = 1'b0;
                    end
                join
                aw_count++;
                last_strb = wr_strb;
                // the error address is never written
                if (wr_addr != err_addr) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wr_strb[i]) mem[wr_addr[5:2]][8*i +: 8] = wr_data[8*i +: 8];
                    end
                end
                repeat (b_delay) @(negedge clk);
                b_valid = 1'b1;
                b_resp  = (wr_addr == err_addr) ? mem_pkg::RESP_SLVERR : mem_pkg::RESP_OKAY;
                while (!b_ready) @(negedge clk);
                @(negedge clk);
                b_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* test/clock_gen.sv */
/* testbench clock with a period of 4, plus a synchronous reset held for 16 cycles
   at start-up and again after each rising edge of reset_req */
`default_nettype none

module clock_gen (
    input  logic reset_req,
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // released on a falling edge, away from the DUT's sampling edge
    initial begin
        rst = 1'b1;
        forever begin
            repeat (16) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            @(posedge reset_req);
            rst = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* test/mem_stage_tb.sv */
/* directed testbench for the memory stage: word, byte and half accesses,
   bus back-pressure and error reporting against a modelled bus memory */
`default_nettype none

module mem_stage_tb;

    localparam int MAX_DELAY  = 4;
    // cycles for one access at the largest modelled delays
    localparam int WAIT_LIMIT = 5 * MAX_DELAY + 8;
    // five tests of at most 30 accesses, period 4, plus margin
    localparam int WATCHDOG_TIME = 5 * 30 * WAIT_LIMIT * 4 + 400;

    logic             clk;
    logic             rst;
    logic             reset_req;
    logic             load_req;
    logic             store_req;
    mem_pkg::addr_t   addr;
    mem_pkg::word_t   store_data;
    mem_pkg::funct3_t funct3;
    mem_pkg::word_t   load_data;
    logic             load_done;
    logic             store_done;
    logic             error;
    logic             ar_valid, ar_ready, r_valid, r_ready;
    logic             aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    mem_pkg::addr_t   ar_addr, aw_addr, err_addr;
    mem_pkg::size_t   ar_size, aw_size;
    mem_pkg::word_t   r_data, w_data;
    mem_pkg::strb_t   w_strb, last_strb;
    mem_pkg::resp_t   b_resp;
    int               ar_delay, r_delay, aw_delay, w_delay, b_delay;
    int               ar_count, aw_count, hold_errors;
    int               seed;
    int               error_count;
    int               tests_run;
    int               tests_failed;

    clock_gen clk_i (.reset_req(reset_req), .clk(clk), .rst(rst));
    mem_stage dut_i (.*);
    bus_memory_model mem_i (.*);

    // ========================================
    // reporting
    task automatic report_mismatch(input string name, input mem_pkg::word_t got,
                                   input mem_pkg::word_t exp);
        $display("ERROR %s: got %h, expected %h", name, got, exp);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("FAILED: %s", what);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        if (error_count == errs_at_start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, error_count - errs_at_start);
        end
    endtask

    // RV32 load result for the field at byte offset off of word w
    function automatic mem_pkg::word_t expected_load(input mem_pkg::word_t w, input int off,
                                                     input mem_pkg::funct3_t f3);
        mem_pkg::word_t field;
        field = w >> (8 * off);
        case (f3)
            mem_pkg::F3_B:  return {{24{field[7]}}, field[7:0]};
            mem_pkg::F3_BU: return {24'd0, field[7:0]};
            mem_pkg::F3_H:  return {{16{field[15]}}, field[15:0]};
            mem_pkg::F3_HU: return {16'd0, field[15:0]};
            default:        return w;
        endcase
    endfunction

    // bus size code, log2 of the bytes moved by the access
    function automatic mem_pkg::size_t expected_size(input mem_pkg::funct3_t f3);
        case (f3)
            mem_pkg::F3_B, mem_pkg::F3_BU: return 3'd0;
            mem_pkg::F3_H, mem_pkg::F3_HU: return 3'd1;
            default:                       return 3'd2;
        endcase
    endfunction

    // ========================================
    // pipeline side
    task automatic wait_reset_release;
        @(negedge clk);
        while (rst !== 1'b0) @(negedge clk);
    endtask

    task automatic issue_load(input mem_pkg::addr_t a, input mem_pkg::funct3_t f3);
        @(negedge clk);
        addr     = a;
        funct3   = f3;
        load_req = 1'b1;
        @(negedge clk);
        load_req = 1'b0;
    endtask

    task automatic issue_store(input mem_pkg::addr_t a, input mem_pkg::word_t d,
                               input mem_pkg::funct3_t f3);
        @(negedge clk);
        addr       = a;
        store_data = d;
        funct3     = f3;
        store_req  = 1'b1;
        @(negedge clk);
        store_req  = 1'b0;
    endtask

    // both done levels high again; neither may rise before its last transfer
    task automatic wait_idle;
        logic rd_wait;
        logic wr_wait;
        logic r_seen;
        logic b_seen;
        int   cycles;
        rd_wait = !load_done;
        wr_wait = !store_done;
        r_seen  = 1'b0;
        b_seen  = 1'b0;
        cycles  = 0;
        while (!(load_done && store_done) && cycles < WAIT_LIMIT) begin
            // transfers happen on the rising edge
            @(posedge clk);
            if (r_valid && r_ready) r_seen = 1'b1;
            if (b_valid && b_ready) b_seen = 1'b1;
            @(negedge clk);
            cycles++;
            if (rd_wait && load_done && !r_seen) begin
                report_failure("load_done rose before the read data transfer");
                rd_wait = 1'b0;
            end
            if (wr_wait && store_done && !b_seen) begin
                report_failure("store_done rose before the write response transfer");
                wr_wait = 1'b0;
            end
        end
        if (!(load_done && store_done)) report_failure("done level did not return in time");
    endtask

    task automatic do_store(input mem_pkg::addr_t a, input mem_pkg::word_t d,
                            input mem_pkg::funct3_t f3);
        issue_store(a, d, f3);
        wait_idle();
        if (aw_size !== expected_size(f3)) begin
            report_mismatch("aw_size", {29'd0, aw_size}, {29'd0, expected_size(f3)});
        end
    endtask

    task automatic check_load(input mem_pkg::addr_t a, input mem_pkg::funct3_t f3,
                              input mem_pkg::word_t exp);
        issue_load(a, f3);
        wait_idle();
        if (load_data !== exp) report_mismatch("load_data", load_data, exp);
        if (ar_size !== expected_size(f3)) begin
            report_mismatch("ar_size", {29'd0, ar_size}, {29'd0, expected_size(f3)});
        end
    endtask

    // ========================================
    // tests
    task automatic word_round_trip;
        int             errs_at_start;
        mem_pkg::word_t data;
        errs_at_start = error_count;
        data = $random(seed);
        do_store(32'h0000_0010, data, mem_pkg::F3_W);
        if (last_strb !== 4'hF) report_mismatch("w_strb", {28'd0, last_strb}, 32'hF);
        check_load(32'h0000_0010, mem_pkg::F3_W, data);
        finish_test("word store and load", errs_at_start);
    endtask

    task automatic narrow_loads;
        int             errs_at_start;
        mem_pkg::word_t base;
        mem_pkg::word_t data;
        mem_pkg::addr_t a;
        errs_at_start = error_count;
        base = $random(seed);
        // second pass flips bit 7 of every byte, so each lane is seen with both signs
        for (int pass = 0; pass < 2; pass++) begin
            data = (pass == 0) ? base : base ^ 32'h8080_8080;
            do_store(32'h0000_0020, data, mem_pkg::F3_W);
            for (int off = 0; off < 4; off++) begin
                a = 32'h0000_0020 + 32'(off);
                check_load(a, mem_pkg::F3_B, expected_load(data, off, mem_pkg::F3_B));
                check_load(a, mem_pkg::F3_BU, expected_load(data, off, mem_pkg::F3_BU));
                if (off % 2 == 0) begin
                    check_load(a, mem_pkg::F3_H, expected_load(data, off, mem_pkg::F3_H));
                    check_load(a, mem_pkg::F3_HU, expected_load(data, off, mem_pkg::F3_HU));
                end
            end
        end
        finish_test("byte and half loads", errs_at_start);
    endtask

    task automatic narrow_stores;
        int             errs_at_start;
        mem_pkg::word_t w;
        mem_pkg::word_t b;
        mem_pkg::word_t h;
        errs_at_start = error_count;
        w = $random(seed);
        b = $random(seed);
        h = $random(seed);
        do_store(32'h0000_0030, w, mem_pkg::F3_W);
        do_store(32'h0000_0031, b, mem_pkg::F3_B);
        if (last_strb !== 4'b0010) report_mismatch("w_strb", {28'd0, last_strb}, 32'h2);
        do_store(32'h0000_0032, h, mem_pkg::F3_H);
        if (last_strb !== 4'b1100) report_mismatch("w_strb", {28'd0, last_strb}, 32'hC);
        check_load(32'h0000_0030, mem_pkg::F3_W, {h[15:0], b[7:0], w[7:0]});
        finish_test("byte and half stores", errs_at_start);
    endtask

    task automatic back_pressure;
        int             errs_at_start;
        mem_pkg::word_t first;
        mem_pkg::word_t second;
        errs_at_start = error_count;
        first  = $random(seed);
        second = $random(seed);
        ar_delay = 3;
        r_delay  = 2;
        aw_delay = MAX_DELAY;
        w_delay  = 1;
        b_delay  = 3;
        do_store(32'h0000_0048, first, mem_pkg::F3_W);
        // store and load in flight together
        issue_store(32'h0000_004c, second, mem_pkg::F3_W);
        issue_load(32'h0000_0048, mem_pkg::F3_W);
        wait_idle();
        if (load_data !== first) report_mismatch("load_data", load_data, first);
        check_load(32'h0000_004c, mem_pkg::F3_W, second);
        if (hold_errors != 0) report_failure("bus payload changed while waiting for ready");
        ar_delay = 0;
        r_delay  = 0;
        aw_delay = 0;
        w_delay  = 0;
        b_delay  = 0;
        finish_test("back-pressure", errs_at_start);
    endtask

    task automatic error_reporting;
        int             errs_at_start;
        int             ar_before;
        int             aw_before;
        logic [7:0]     status;
        errs_at_start = error_count;
        err_addr = 32'h0000_0050;
        do_store(32'h0000_0050, $random(seed), mem_pkg::F3_W);
        if (error !== 1'b1) report_mismatch("error", {31'd0, error}, 32'h1);
        @(negedge clk);
        reset_req = 1'b1;
        @(negedge clk);
        reset_req = 1'b0;
        wait_reset_release();
        status = {ar_valid, aw_valid, w_valid, r_ready, b_ready, load_done, store_done, error};
        if (status !== 8'b0000_0110) report_mismatch("status after reset", {24'd0, status},
                                                     32'h06);
        ar_before = ar_count;
        aw_before = aw_count;
        issue_load(32'h0000_0012, mem_pkg::F3_W);
        if (error !== 1'b1) report_mismatch("error", {31'd0, error}, 32'h1);
        repeat (4) @(negedge clk);
        if (ar_count != ar_before || aw_count != aw_before) begin
            report_failure("misaligned load started a bus transaction");
        end
        if (load_done !== 1'b1) report_mismatch("load_done", {31'd0, load_done}, 32'h1);
        finish_test("error reporting", errs_at_start);
    endtask

    // ========================================
    // main sequence and watchdog
    initial begin
        seed         = 32'he7ac_8520;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_req    = 1'b0;
        load_req     = 1'b0;
        store_req    = 1'b0;
        addr         = '0;
        store_data   = '0;
        funct3       = mem_pkg::F3_W;
        ar_delay     = 0;
        r_delay      = 0;
        aw_delay     = 0;
        w_delay      = 0;
        b_delay      = 0;
        err_addr     = 32'hffff_fff0;
        wait_reset_release();
        word_round_trip();
        narrow_loads();
        narrow_stores();
        back_pressure();
        error_reporting();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units, tests stopped", WATCHDOG_TIME);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
